// ==== Makefile ====
SIM   = verilator
FLAGS = --binary --timing --assert -Wno-fatal
TOP   = tb_sw_align
FLIST = sw_align.f
OBJ   = obj_dir
LOG   = sim.log

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ) -f $(FLIST)
	-./$(OBJ)/V$(TOP) | tee $(LOG)
	grep -q "Everything OK" $(LOG)

clean:
	rm -rf $(OBJ) $(LOG)

// ==== sw_align.f ====
sw_seq_pkg.sv
sw_ctrl_pkg.sv
sw_step_counter.sv
sw_array_fsm.sv
sw_query_bank.sv
sw_cell.sv
sw_align_top.sv
sw_align_chk.sv
tb_sw_align.sv

// ==== tb_sw_align.sv ====
`timescale 1ns/1ps

module tb_sw_align;

    localparam int NUM_CELLS = sw_seq_pkg::NUM_CELLS_DEF;
    localparam int SCORE_W   = sw_seq_pkg::SCORE_W_DEF;
    localparam int CNT_W     = $clog2(NUM_CELLS + 1);
    localparam int IDX_W     = (NUM_CELLS > 1) ? $clog2(NUM_CELLS) : 1;
    localparam int MAX_T     = 20;                  // longest target used below
    localparam int TIMEOUT   = 4 * NUM_CELLS + 16;  // drain alone is NUM_CELLS cycles
    localparam int MATCH     = 2;
    localparam int MISMATCH  = -1;
    localparam int GAP       = -1;

    typedef logic signed [SCORE_W-1:0] score_t;
    typedef logic [IDX_W-1:0]          idx_t;

    logic clk = 1'b0;
    logic rst, start, query_wr, target_valid, target_last, busy, done;
    logic [CNT_W-1:0]  query_len;
    sw_seq_pkg::base_t query_base, target_base;
    score_t            match_score, mismatch_score, gap_open, best_score;
    idx_t              best_query_idx;

    sw_seq_pkg::base_t q_seq [NUM_CELLS];  // query of the current run
    sw_seq_pkg::base_t t_seq [MAX_T];      // target of the current run
    logic [15:0]       lfsr_q;
    int                exp_score, exp_row;

    sw_align_top #(.NUM_CELLS(NUM_CELLS), .SCORE_W(SCORE_W)) dut_i (.*);

    always #5 clk = ~clk;  // 10 ns period

    //////////////////////////////////////////////////
    // random bases and the software scorer
    //////////////////////////////////////////////////

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);  // galois, taps 16 14 13 11
    endfunction

    function automatic int draw_bits(input int n);
        int v;
        v = 0;
        for (int b = 0; b < n; b++) begin
            v = (v << 1) | int'(lfsr_q[0]);  // one lfsr step per bit
            lfsr_q = lfsr_next(lfsr_q);
        end
        return v;
    endfunction

    function automatic int imax(input int a, input int b);
        return (a > b) ? a : b;
    endfunction

    task automatic fill_random(input int qlen, input int tlen);
        for (int i = 0; i < qlen; i++) begin
            q_seq[i] = sw_seq_pkg::base_t'(draw_bits(2));
        end
        for (int j = 0; j < tlen; j++) begin
            t_seq[j] = sw_seq_pkg::base_t'(draw_bits(2));
        end
    endtask

    // full matrix, row 0 and column 0 are the zero boundary
    task automatic ref_align(input int qlen, input int tlen);
        int h [NUM_CELLS+1][MAX_T+1];
        int sub;
        exp_score = 0;
        exp_row   = 0;  // stays 0 when nothing scores
        for (int i = 0; i <= qlen; i++) begin
            for (int j = 0; j <= tlen; j++) begin
                if (i == 0 || j == 0) begin
                    h[i][j] = 0;
                end else begin
                    sub     = (q_seq[i-1] == t_seq[j-1]) ? MATCH : MISMATCH;
                    h[i][j] = imax(imax(0, h[i-1][j-1] + sub),
                                   imax(h[i][j-1] + GAP, h[i-1][j] + GAP));
                    if (h[i][j] > exp_score) begin  // strict, keeps the smallest row
                        exp_score = h[i][j];
                        exp_row   = i - 1;
                    end
                end
            end
        end
    endtask

    //////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////

    task automatic abort_run();
        $display("Something failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_score(input string name, input score_t got, input score_t exp);
        if (got !== exp) begin
            $display("Fail at %0t: %s = %0d, expected %0d", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_idx(input string name, input idx_t got, input idx_t exp);
        if (got !== exp) begin
            $display("Fail at %0t: %s = %0d, expected %0d", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic wait_done();
        int n;
        n = 0;
        do begin
            @(negedge clk);  // outputs settled mid cycle
            n++;
        end while (!done && n < TIMEOUT);
        if (!done) begin
            $display("no done pulse within %0d cycles", TIMEOUT);
            abort_run();
        end
    endtask

    //////////////////////////////////////////////////
    // one full pass, load then stream then check
    //////////////////////////////////////////////////

    task automatic run_align(input int qlen, input int tlen, input bit bubbles);
        @(posedge clk);
        start     <= 1'b1;
        query_len <= CNT_W'(qlen);
        @(posedge clk);
        start <= 1'b0;
        for (int i = 0; i < qlen; i++) begin
            repeat (bubbles ? draw_bits(2) : 0) begin  // gap between writes
                @(posedge clk);
                query_wr <= 1'b0;
            end
            @(posedge clk);
            query_wr   <= 1'b1;
            query_base <= q_seq[i];
        end
        @(posedge clk);
        query_wr <= 1'b0;
        for (int j = 0; j < tlen; j++) begin
            repeat (bubbles ? draw_bits(2) : 0) begin
                @(posedge clk);
                target_valid <= 1'b0;
            end
            @(posedge clk);
            target_valid <= 1'b1;
            target_base  <= t_seq[j];
            target_last  <= (j == tlen - 1);
        end
        @(posedge clk);
        target_valid <= 1'b0;
        target_last  <= 1'b0;
        wait_done();
        check_score("best_score", best_score, score_t'(exp_score));
        check_idx("best_query_idx", best_query_idx, idx_t'(exp_row));
    endtask

    task automatic test_reset_idle();
        @(negedge clk);
        if (busy || done) begin
            $display("busy or done is high right after reset");
            abort_run();
        end
        @(posedge clk);
        target_valid <= 1'b1;  // stray column, no start seen yet
        target_last  <= 1'b1;
        @(posedge clk);
        target_valid <= 1'b0;
        target_last  <= 1'b0;
        for (int n = 0; n < TIMEOUT; n++) begin
            @(negedge clk);
            if (done || busy) begin
                $display("a target strobe without start woke up the engine");
                abort_run();
            end
        end
    endtask

    task automatic test_exact_hit();
        fill_random(0, 12);
        for (int i = 0; i < 5; i++) begin
            q_seq[i] = t_seq[i + 4];  // query copied out of the target
        end
        exp_score = 5 * MATCH;
        exp_row   = 4;                // last query row closes the hit
        run_align(5, 12, 1'b0);
    endtask

    task automatic test_random(input int rounds);
        int qlen, tlen;
        for (int r = 0; r < rounds; r++) begin
            qlen = draw_bits(3) + 1;
            tlen = draw_bits(4) + 4;
            fill_random(qlen, tlen);
            ref_align(qlen, tlen);
            run_align(qlen, tlen, 1'b0);
            run_align(qlen, tlen, 1'b1);  // same data, bubbles everywhere
        end
    endtask

    task automatic test_no_common();
        for (int i = 0; i < 5; i++) begin
            q_seq[i] = sw_seq_pkg::base_t'(draw_bits(1));      // A or C only
        end
        for (int j = 0; j < 10; j++) begin
            t_seq[j] = sw_seq_pkg::base_t'(2 + draw_bits(1));  // G or T only
        end
        exp_score = 0;
        exp_row   = 0;
        run_align(5, 10, 1'b0);
        fill_random(NUM_CELLS, 16);  // full array right after a short query
        ref_align(NUM_CELLS, 16);
        run_align(NUM_CELLS, 16, 1'b1);
    endtask

    initial begin
        rst            = 1'b1;
        start          = 1'b0;
        query_len      = '0;
        query_wr       = 1'b0;
        query_base     = sw_seq_pkg::BASE_A;
        target_valid   = 1'b0;
        target_base    = sw_seq_pkg::BASE_A;
        target_last    = 1'b0;
        match_score    = score_t'(MATCH);
        mismatch_score = score_t'(MISMATCH);
        gap_open       = score_t'(GAP);
        lfsr_q         = 16'd472;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        test_reset_idle();
        test_exact_hit();
        test_random(6);
        test_no_common();
        $display("Everything OK");
        $finish;
    end

endmodule

// ==== sw_align_chk.sv ====
`timescale 1ns/1ps

module sw_align_chk #(
    parameter int SCORE_W = 10
) (
    input logic                      clk,
    input logic                      rst,
    input logic                      busy,
    input logic                      done,
    input logic signed [SCORE_W-1:0] best_score,
    input sw_ctrl_pkg::sw_state_t    state       // controller phase
);

    //////////////////////////////////////////////////
    // status outputs
    //////////////////////////////////////////////////

    a_done_pulse: assert property (@(posedge clk) disable iff (rst) done |=> !done)
        else $error("done stayed high for more than one cycle");

    a_done_after_busy: assert property (@(posedge clk) disable iff (rst) done |-> $past(busy))
        else $error("done without busy in the cycle before");

    a_score_floor: assert property (@(posedge clk) disable iff (rst) done |-> best_score >= 0)
        else $error("negative best score at done");

    a_reset_idle: assert property (@(posedge clk) rst |=> !busy && state == sw_ctrl_pkg::IDLE)
        else $error("controller not idle after reset");

endmodule

bind sw_align_top sw_align_chk #(.SCORE_W(SCORE_W)) chk_i (
    .clk, .rst, .busy, .done, .best_score, .state(fsm_i.state)
);

// ==== sw_align_top.sv ====
`timescale 1ns/1ps

module sw_align_top #(
    parameter int   NUM_CELLS = sw_seq_pkg::NUM_CELLS_DEF,
    parameter int   SCORE_W   = sw_seq_pkg::SCORE_W_DEF,
    localparam int  CNT_W     = $clog2(NUM_CELLS + 1),  // holds NUM_CELLS itself
    localparam int  IDX_W     = (NUM_CELLS > 1) ? $clog2(NUM_CELLS) : 1
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      start,
    input  logic        [CNT_W-1:0]   query_len,
    input  logic                      query_wr,
    input  sw_seq_pkg::base_t         query_base,
    input  logic                      target_valid,
    input  sw_seq_pkg::base_t         target_base,
    input  logic                      target_last,
    input  logic signed [SCORE_W-1:0] match_score,
    input  logic signed [SCORE_W-1:0] mismatch_score,
    input  logic signed [SCORE_W-1:0] gap_open,
    output logic                      busy,
    output logic                      done,
    output logic signed [SCORE_W-1:0] best_score,
    output logic        [IDX_W-1:0]   best_query_idx
);

    logic cnt_clr, cnt_inc, count_hit, bank_wr, bank_clr;
    logic [CNT_W-1:0] count, cnt_limit;
    logic [IDX_W-1:0] bank_idx;
    sw_seq_pkg::base_t [NUM_CELLS-1:0] bases;
    logic [NUM_CELLS-1:0] row_en;

    // chain taps, entry k feeds cell k, entry NUM_CELLS is the array output
    logic                      valid_c  [NUM_CELLS+1];
    logic                      first_c  [NUM_CELLS+1];
    sw_seq_pkg::base_t         target_c [NUM_CELLS+1];
    logic signed [SCORE_W-1:0] h_c      [NUM_CELLS+1];
    logic signed [SCORE_W-1:0] hmax_c   [NUM_CELLS+1];
    logic        [IDX_W-1:0]   hidx_c   [NUM_CELLS+1];

    sw_array_fsm #(.NUM_CELLS(NUM_CELLS), .CNT_W(CNT_W)) fsm_i (
        .clk, .rst, .start, .query_len, .query_wr, .target_valid, .target_last,
        .count, .count_hit, .cnt_clr, .cnt_inc, .cnt_limit, .bank_wr, .bank_idx,
        .bank_clr, .col_valid(valid_c[0]), .col_first(first_c[0]), .busy, .done
    );

    sw_step_counter #(.CNT_W(CNT_W)) cnt_i (
        .clk, .rst, .clr(cnt_clr), .inc(cnt_inc), .limit(cnt_limit), .count, .hit(count_hit)
    );

    sw_query_bank #(.NUM_CELLS(NUM_CELLS)) bank_i (
        .clk, .rst, .clr(bank_clr), .wr(bank_wr), .idx(bank_idx), .base(query_base),
        .bases, .row_en
    );

    //////////////////////////////////////////////////
    // systolic chain, top row boundary is zero
    //////////////////////////////////////////////////

    assign target_c[0] = target_base;
    assign h_c[0]      = '0;
    assign hmax_c[0]   = '0;
    assign hidx_c[0]   = '0;

    for (genvar k = 0; k < NUM_CELLS; k++) begin : g_cell
        sw_cell #(.SCORE_W(SCORE_W), .NUM_CELLS(NUM_CELLS), .INDEX(k)) cell_i (
            .clk, .rst, .query(bases[k]), .query_en(row_en[k]),
            .match_score, .mismatch_score, .gap_open,
            .valid_in(valid_c[k]), .first_in(first_c[k]), .target_in(target_c[k]),
            .h_in(h_c[k]), .h_max_in(hmax_c[k]), .h_max_idx_in(hidx_c[k]),
            .valid_out(valid_c[k+1]), .first_out(first_c[k+1]), .target_out(target_c[k+1]),
            .h_out(h_c[k+1]), .h_max_out(hmax_c[k+1]), .h_max_idx_out(hidx_c[k+1])
        );
    end

    assign best_score     = hmax_c[NUM_CELLS];  // last cell sees every row
    assign best_query_idx = hidx_c[NUM_CELLS];

endmodule

// ==== sw_cell.sv ====
`timescale 1ns/1ps

module sw_cell #(
    parameter int   SCORE_W   = 10,
    parameter int   NUM_CELLS = 8,
    parameter int   INDEX     = 0,  // query row held by this cell
    localparam int  IDX_W     = (NUM_CELLS > 1) ? $clog2(NUM_CELLS) : 1
) (
    input  logic                      clk,
    input  logic                      rst,
    input  sw_seq_pkg::base_t         query,
    input  logic                      query_en,
    input  logic signed [SCORE_W-1:0] match_score,
    input  logic signed [SCORE_W-1:0] mismatch_score,
    input  logic signed [SCORE_W-1:0] gap_open,
    input  logic                      valid_in,
    input  logic                      first_in,
    input  sw_seq_pkg::base_t         target_in,
    input  logic signed [SCORE_W-1:0] h_in,          // H[i-1][j]
    input  logic signed [SCORE_W-1:0] h_max_in,      // best over rows above
    input  logic        [IDX_W-1:0]   h_max_idx_in,
    output logic                      valid_out,
    output logic                      first_out,
    output sw_seq_pkg::base_t         target_out,
    output logic signed [SCORE_W-1:0] h_out,         // H[i][j], left score next column
    output logic signed [SCORE_W-1:0] h_max_out,
    output logic        [IDX_W-1:0]   h_max_idx_out
);

    logic signed [SCORE_W-1:0] h_diag;      // h_in of the previous column
    logic signed [SCORE_W-1:0] diag, left;  // zeroed on the first column
    logic signed [SCORE_W-1:0] sub;
    logic signed [SCORE_W-1:0] s_diag, s_left, s_up, score;
    logic signed [SCORE_W-1:0] next_h;
    logic signed [SCORE_W-1:0] old_max;     // stored max, restarted per run
    logic        [IDX_W-1:0]   old_idx;

    function automatic logic signed [SCORE_W-1:0] smax(input logic signed [SCORE_W-1:0] a,
                                                       input logic signed [SCORE_W-1:0] b);
        smax = (a < b) ? b : a;  // signed compare, a wins a tie
    endfunction

    //////////////////////////////////////////////////
    // score for this column
    //////////////////////////////////////////////////

    assign diag   = first_in ? '0 : h_diag;  // left boundary of the matrix
    assign left   = first_in ? '0 : h_out;
    assign sub    = (query == target_in) ? match_score : mismatch_score;
    assign s_diag = diag + sub;
    assign s_left = left + gap_open;          // linear gap, open only
    assign s_up   = h_in + gap_open;
    assign score  = smax(smax('0, s_diag), smax(s_left, s_up));  // clip at zero
    assign next_h = query_en ? score : h_in;  // unused row just forwards

    // stored max from a previous target must not leak into this run
    assign old_max = first_in ? '0 : h_max_out;
    assign old_idx = first_in ? '0 : h_max_idx_out;

    //////////////////////////////////////////////////
    // systolic registers
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_out <= 1'b0;
            first_out <= 1'b0;
        end else begin
            valid_out <= valid_in;  // bubbles travel down as well
            first_out <= first_in;
        end
    end

    always_ff @(posedge clk) begin
        target_out <= target_in;  // qualified by valid_out downstream
        if (valid_in) begin
            h_diag <= h_in;
            h_out  <= next_h;
        end
    end

    // running max, ties go above, then stored, then new
    always_ff @(posedge clk) begin
        if (rst) begin
            h_max_out     <= '0;
            h_max_idx_out <= '0;
        end else if (valid_in) begin
            if (h_max_in >= old_max && h_max_in >= next_h) begin
                h_max_out     <= h_max_in;
                h_max_idx_out <= h_max_idx_in;
            end else if (old_max >= next_h) begin
                h_max_out     <= old_max;
                h_max_idx_out <= old_idx;
            end else begin
                h_max_out     <= next_h;
                h_max_idx_out <= IDX_W'(INDEX);
            end
        end
    end

endmodule

// ==== sw_query_bank.sv ====
`timescale 1ns/1ps

module sw_query_bank #(
    parameter int   NUM_CELLS = 8,
    localparam int  IDX_W     = (NUM_CELLS > 1) ? $clog2(NUM_CELLS) : 1
) (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                clr,    // new query coming
    input  logic                                wr,
    input  logic [IDX_W-1:0]                    idx,    // row being written
    input  sw_seq_pkg::base_t                   base,
    output sw_seq_pkg::base_t [NUM_CELLS-1:0]   bases,  // one base per cell
    output logic [NUM_CELLS-1:0]                row_en  // row holds a real base
);

    //////////////////////////////////////////////////
    // row enables
    //////////////////////////////////////////////////

    // rows never written after clr stay off, so cells past query_len
    // just forward the upper score
    always_ff @(posedge clk) begin
        if (rst) begin
            row_en <= '0;
        end else if (clr) begin
            row_en <= '0;
        end else if (wr) begin
            row_en[idx] <= 1'b1;
        end
    end

    //////////////////////////////////////////////////
    // base storage
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (wr) begin
            bases[idx] <= base;  // no reset, qualified by row_en
        end
    end

endmodule

// ==== sw_array_fsm.sv ====
`timescale 1ns/1ps

module sw_array_fsm #(
    parameter int   NUM_CELLS = 8,
    parameter int   CNT_W     = 4,
    localparam int  IDX_W     = (NUM_CELLS > 1) ? $clog2(NUM_CELLS) : 1
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             start,         // pulse, only seen in idle
    input  logic [CNT_W-1:0] query_len,     // 1 .. NUM_CELLS
    input  logic             query_wr,
    input  logic             target_valid,
    input  logic             target_last,
    input  logic [CNT_W-1:0] count,
    input  logic             count_hit,
    output logic             cnt_clr,
    output logic             cnt_inc,
    output logic [CNT_W-1:0] cnt_limit,
    output logic             bank_wr,
    output logic [IDX_W-1:0] bank_idx,
    output logic             bank_clr,
    output logic             col_valid,     // column strobe into cell 0
    output logic             col_first,     // first column of this run
    output logic             busy,
    output logic             done
);

    sw_ctrl_pkg::sw_state_t state;
    logic [CNT_W-1:0]       len_q;       // latched query length
    logic                   first_pend;  // no target base taken yet

    //////////////////////////////////////////////////
    // phase sequencing
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= sw_ctrl_pkg::IDLE;
            first_pend <= 1'b0;
        end else begin
            case (state)
                sw_ctrl_pkg::IDLE:   if (start) state <= sw_ctrl_pkg::LOAD;
                sw_ctrl_pkg::LOAD:   if (query_wr && count_hit) state <= sw_ctrl_pkg::STREAM;
                sw_ctrl_pkg::STREAM: if (target_valid && target_last) state <= sw_ctrl_pkg::DRAIN;
                sw_ctrl_pkg::DRAIN:  if (count_hit) state <= sw_ctrl_pkg::DONE;
                sw_ctrl_pkg::DONE:   state <= sw_ctrl_pkg::IDLE;  // one cycle only
                default:             state <= sw_ctrl_pkg::IDLE;
            endcase
            if (state == sw_ctrl_pkg::LOAD && query_wr && count_hit) begin
                first_pend <= 1'b1;  // arm for the first streamed base
            end else if (col_valid) begin
                first_pend <= 1'b0;
            end
        end
    end

    // length is payload, only sampled on an accepted start
    always_ff @(posedge clk) begin
        if (state == sw_ctrl_pkg::IDLE && start) begin
            len_q <= query_len;
        end
    end

    //////////////////////////////////////////////////
    // strobes, all decoded from the phase
    //////////////////////////////////////////////////

    assign bank_clr  = (state == sw_ctrl_pkg::IDLE) && start;  // drop old row enables
    assign bank_wr   = (state == sw_ctrl_pkg::LOAD) && query_wr;
    assign bank_idx  = count[IDX_W-1:0];                       // write index = rows so far

    assign col_valid = (state == sw_ctrl_pkg::STREAM) && target_valid;
    assign col_first = col_valid && first_pend;

    // counter only moves in load and drain, parked at zero elsewhere
    assign cnt_clr   = (state != sw_ctrl_pkg::LOAD) && (state != sw_ctrl_pkg::DRAIN);
    assign cnt_inc   = bank_wr || (state == sw_ctrl_pkg::DRAIN);
    assign cnt_limit = (state == sw_ctrl_pkg::DRAIN) ? CNT_W'(NUM_CELLS) : len_q;

    assign busy = (state == sw_ctrl_pkg::LOAD) || (state == sw_ctrl_pkg::STREAM) ||
                  (state == sw_ctrl_pkg::DRAIN);
    assign done = (state == sw_ctrl_pkg::DONE);

endmodule

// ==== sw_step_counter.sv ====
`timescale 1ns/1ps

module sw_step_counter #(
    parameter int CNT_W = 4
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             clr,    // back to zero, wins over inc
    input  logic             inc,
    input  logic [CNT_W-1:0] limit,  // terminal count for the current phase
    output logic [CNT_W-1:0] count,
    output logic             hit     // next inc reaches limit
);

    logic [CNT_W-1:0] last_val;  // limit minus one

    assign last_val = limit - CNT_W'(1);

    // look ahead by one so the controller can switch phase on the same edge
    // as the final increment, no idle cycle in between
    assign hit = (count == last_val);

    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
        end else if (clr) begin
            count <= '0;
        end else if (inc) begin
            count <= count + CNT_W'(1);  // wraps, never exceeds limit in use
        end
    end

endmodule

// ==== sw_ctrl_pkg.sv ====
package sw_ctrl_pkg;

    //////////////////////////////////////////////////
    // controller phases
    //////////////////////////////////////////////////

    // one pass: load query, stream target, drain the array, flag done
    typedef enum logic [2:0] {
        IDLE   = 3'd0,  // waiting for start
        LOAD   = 3'd1,  // query bases written into the bank
        STREAM = 3'd2,  // target columns enter cell 0
        DRAIN  = 3'd3,  // last column walks down the chain
        DONE   = 3'd4   // single cycle, results valid
    } sw_state_t;

endpackage

// ==== sw_seq_pkg.sv ====
package sw_seq_pkg;

    //////////////////////////////////////////////////
    // nucleotide encoding
    //////////////////////////////////////////////////

    // 2 bit code per base, shared by query and target streams
    typedef enum logic [1:0] {
        BASE_A = 2'd0,
        BASE_C = 2'd1,
        BASE_G = 2'd2,
        BASE_T = 2'd3
    } base_t;

    //////////////////////////////////////////////////
    // score and array sizing defaults
    //////////////////////////////////////////////////

    // signed score width, enough headroom for 8 rows of small match values
    localparam int SCORE_W_DEF = 10;

    // number of systolic cells, i.e. longest query the array can hold
    localparam int NUM_CELLS_DEF = 8;

    // scores never go below zero inside the array (local alignment floor)

endpackage
